//--- common/xform_params.svh
`ifndef XFORM_PARAMS_SVH
`define XFORM_PARAMS_SVH

// word format
`define XFORM_W         16  // signed q3.12 word
`define XFORM_FRAC      12  // fraction bits

// stage latencies in clk cycles
`define XFORM_SCALE_LAT 1                                           // per-axis multiply
`define XFORM_QMUL_LAT  2                                           // products, then sums
`define XFORM_ROT_LAT   (2 * `XFORM_QMUL_LAT)                       // q*v, then (q*v)*q'
`define XFORM_TRANS_LAT 1                                           // per-axis add
`define XFORM_LAT       (`XFORM_SCALE_LAT + `XFORM_ROT_LAT + `XFORM_TRANS_LAT)

`endif

//--- common/xform_pkg.sv
`default_nettype none

`include "xform_params.svh"

package xform_pkg;

    typedef logic signed [`XFORM_W-1:0] fixed_t;      // one q3.12 word
    typedef logic signed [2*`XFORM_W+1:0] acc_t;      // wide enough for 4-term sums

    typedef struct packed {
        fixed_t x;
        fixed_t y;
        fixed_t z;
    } vec3_t;

    typedef struct packed {
        fixed_t r;                                    // real part
        fixed_t i;
        fixed_t j;
        fixed_t k;
    } quat_t;

    typedef struct packed {
        vec3_t point;
        vec3_t scale;
        quat_t rot;                                   // unit quaternion expected
        vec3_t trans;
    } xform_req_t;

    localparam fixed_t FX_MAX = {1'b0, {(`XFORM_W-1){1'b1}}};  // 0x7fff
    localparam fixed_t FX_MIN = {1'b1, {(`XFORM_W-1){1'b0}}};  // 0x8000

    // clamp a wide signed value into one word
    function automatic fixed_t sat_fixed(input acc_t v);
        if (v > acc_t'(FX_MAX)) begin
            return FX_MAX;
        end else if (v < acc_t'(FX_MIN)) begin
            return FX_MIN;
        end
        return v[`XFORM_W-1:0];
    endfunction

    // a*b then arithmetic shift drops fraction (floor) and clamps
    function automatic fixed_t fx_mul(input fixed_t a, input fixed_t b);
        acc_t prod;
        prod = acc_t'(a) * acc_t'(b);                 // full signed product
        return sat_fixed(prod >>> `XFORM_FRAC);
    endfunction

    // conjugate with negation done wide so -min clamps to max
    function automatic quat_t fx_conj(input quat_t q);
        quat_t c;
        c.r = q.r;
        c.i = sat_fixed(-acc_t'(q.i));
        c.j = sat_fixed(-acc_t'(q.j));
        c.k = sat_fixed(-acc_t'(q.k));
        return c;
    endfunction

endpackage

`default_nettype wire

//--- rtl/pipe_delay.sv
`default_nettype none
`timescale 1ns/100ps

// plain register chain, payload only, no valid
module pipe_delay #(
    parameter type T     = logic,                     // payload type
    parameter int  DEPTH = 1                          // cycles of delay, >= 1
) (
    input  wire clk,
    input  wire T data_in,
    output T      data_out
);

    T stage [DEPTH];                                  // stage[0] loads first

    always_ff @(posedge clk) begin
        stage[0] <= data_in;
        for (int n = 1; n < DEPTH; n++) begin
            stage[n] <= stage[n-1];                   // shift one step per clk
        end
    end

    assign data_out = stage[DEPTH-1];                 // oldest entry

endmodule

`default_nettype wire

//--- rtl/vec_scale.sv
`default_nettype none
`timescale 1ns/100ps

// per-axis multiply, one cycle
module vec_scale (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     in_valid,
    input  wire xform_pkg::vec3_t   point,
    input  wire xform_pkg::vec3_t   scale,
    output logic                    out_valid,
    output xform_pkg::vec3_t        out
);

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;                    // strobe rides with data
        end
    end

    // payload regs, loaded every cycle
    always_ff @(posedge clk) begin
        out.x <= xform_pkg::fx_mul(point.x, scale.x);
        out.y <= xform_pkg::fx_mul(point.y, scale.y);
        out.z <= xform_pkg::fx_mul(point.z, scale.z);
    end

endmodule

`default_nettype wire

//--- rotate/quat_mult.sv
`default_nettype none
`timescale 1ns/100ps

// hamilton product a*b, two stages
// stage 1 registers all 16 cross products, stage 2 the signed 4-term sums
module quat_mult (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     in_valid,
    input  wire xform_pkg::quat_t   a,
    input  wire xform_pkg::quat_t   b,
    output logic                    out_valid,
    output xform_pkg::quat_t        out
);

    xform_pkg::fixed_t a_c [4];                       // index 0..3 = r,i,j,k
    xform_pkg::fixed_t b_c [4];
    xform_pkg::fixed_t prod [4][4];                   // prod[m][n] = a_m * b_n
    logic              prod_valid;

    // sign-extend one product to sum width
    function automatic xform_pkg::acc_t ext(input xform_pkg::fixed_t v);
        return xform_pkg::acc_t'(v);
    endfunction

    assign a_c[0] = a.r;
    assign a_c[1] = a.i;
    assign a_c[2] = a.j;
    assign a_c[3] = a.k;

    assign b_c[0] = b.r;
    assign b_c[1] = b.i;
    assign b_c[2] = b.j;
    assign b_c[3] = b.k;

    always_ff @(posedge clk) begin
        if (rst) begin
            prod_valid <= 1'b0;
            out_valid  <= 1'b0;
        end else begin
            prod_valid <= in_valid;                   // stage 1
            out_valid  <= prod_valid;                 // stage 2
        end
    end

    // stage 1, each product shifted and clamped
    always_ff @(posedge clk) begin
        for (int m = 0; m < 4; m++) begin
            for (int n = 0; n < 4; n++) begin
                prod[m][n] <= xform_pkg::fx_mul(a_c[m], b_c[n]);
            end
        end
    end

    // stage 2, summed wide then clamped once
    always_ff @(posedge clk) begin
        out.r <= xform_pkg::sat_fixed(ext(prod[0][0]) - ext(prod[1][1])
                                    - ext(prod[2][2]) - ext(prod[3][3]));   // ar br - a.b
        out.i <= xform_pkg::sat_fixed(ext(prod[0][1]) + ext(prod[1][0])
                                    + ext(prod[2][3]) - ext(prod[3][2]));
        out.j <= xform_pkg::sat_fixed(ext(prod[0][2]) - ext(prod[1][3])
                                    + ext(prod[2][0]) + ext(prod[3][1]));
        out.k <= xform_pkg::sat_fixed(ext(prod[0][3]) + ext(prod[1][2])
                                    - ext(prod[2][1]) + ext(prod[3][0]));
    end

endmodule

`default_nettype wire

//--- rotate/vec_rotate.sv
`default_nettype none
`timescale 1ns/100ps

`include "xform_params.svh"

// v' = q * v * q', two chained products
module vec_rotate (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     in_valid,
    input  wire xform_pkg::vec3_t   point,
    input  wire xform_pkg::quat_t   rot,
    output logic                    out_valid,
    output xform_pkg::vec3_t        out
);

    xform_pkg::quat_t p_quat;                         // point as pure quaternion
    xform_pkg::quat_t rot_p;                          // q * v
    xform_pkg::quat_t conj_d;                         // q' lined up with rot_p
    xform_pkg::quat_t rot_full;                       // q * v * q'
    logic             rot_p_valid;

    assign p_quat = '{r: '0, i: point.x, j: point.y, k: point.z};

    quat_mult u_fwd (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .a         (rot),
        .b         (p_quat),
        .out_valid (rot_p_valid),
        .out       (rot_p)
    );

    // conjugate taken at entry, held for the first product
    pipe_delay #(
        .T     (xform_pkg::quat_t),
        .DEPTH (`XFORM_QMUL_LAT)
    ) u_conj_dly (
        .clk      (clk),
        .data_in  (xform_pkg::fx_conj(rot)),
        .data_out (conj_d)
    );

    quat_mult u_back (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (rot_p_valid),
        .a         (rot_p),
        .b         (conj_d),
        .out_valid (out_valid),
        .out       (rot_full)
    );

    // real part ~0 for unit q, dropped
    assign out = '{x: rot_full.i, y: rot_full.j, z: rot_full.k};

endmodule

`default_nettype wire

//--- rtl/vec_translate.sv
`default_nettype none
`timescale 1ns/100ps

// per-axis add, one cycle
module vec_translate (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     in_valid,
    input  wire xform_pkg::vec3_t   point,
    input  wire xform_pkg::vec3_t   trans,
    output logic                    out_valid,
    output xform_pkg::vec3_t        out
);

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    // sums formed wide so overflow clamps instead of wrapping
    always_ff @(posedge clk) begin
        out.x <= xform_pkg::sat_fixed(xform_pkg::acc_t'(point.x) + xform_pkg::acc_t'(trans.x));
        out.y <= xform_pkg::sat_fixed(xform_pkg::acc_t'(point.y) + xform_pkg::acc_t'(trans.y));
        out.z <= xform_pkg::sat_fixed(xform_pkg::acc_t'(point.z) + xform_pkg::acc_t'(trans.z));
    end

endmodule

`default_nettype wire

//--- rtl/xform_top.sv
`default_nettype none
`timescale 1ns/100ps

`include "xform_params.svh"

// scale -> rotate -> translate, fixed latency, no backpressure
module xform_top (
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       in_valid,
    input  wire xform_pkg::xform_req_t req,
    output logic                      out_valid,
    output xform_pkg::vec3_t          out
);

    xform_pkg::vec3_t scaled;                         // after scale stage
    xform_pkg::vec3_t rotated;                        // after rotate stage
    xform_pkg::quat_t rot_d;                          // rot aligned to scaled
    xform_pkg::vec3_t trans_d;                        // trans aligned to rotated
    logic             scaled_valid;
    logic             rotated_valid;

    vec_scale u_scale (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .point     (req.point),
        .scale     (req.scale),
        .out_valid (scaled_valid),
        .out       (scaled)
    );

    pipe_delay #(
        .T     (xform_pkg::quat_t),
        .DEPTH (`XFORM_SCALE_LAT)
    ) u_rot_dly (
        .clk      (clk),
        .data_in  (req.rot),
        .data_out (rot_d)
    );

    vec_rotate u_rotate (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (scaled_valid),
        .point     (scaled),
        .rot       (rot_d),
        .out_valid (rotated_valid),
        .out       (rotated)
    );

    // skips scale and rotate
    pipe_delay #(
        .T     (xform_pkg::vec3_t),
        .DEPTH (`XFORM_SCALE_LAT + `XFORM_ROT_LAT)
    ) u_trans_dly (
        .clk      (clk),
        .data_in  (req.trans),
        .data_out (trans_d)
    );

    vec_translate u_translate (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (rotated_valid),
        .point     (rotated),
        .trans     (trans_d),
        .out_valid (out_valid),
        .out       (out)
    );

endmodule

`default_nettype wire

//--- verif/xform_checker.sv
`default_nettype none
`timescale 1ns/100ps

`include "xform_params.svh"

// watches the dut ports, expected rows come from the vectors file
module xform_checker (
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   in_valid,
    input  wire                   out_valid,
    input  wire xform_pkg::vec3_t out,
    output logic                  done,
    output int                    value_errors,
    output int                    latency_errors,
    output int                    count_errors
);

    localparam string VEC_FILE = "verif/xform_vectors.txt";

    string            names [$];                      // tag per row
    xform_pkg::vec3_t expect_q [$];                   // expected out per row
    int               stamps [$];                     // accept cycle, oldest first
    int               rows = 0;
    int               next_row = 0;                   // next row to compare
    int               cycle = 0;
    int               value_errs = 0;
    int               latency_errs = 0;
    int               count_errs = 0;

    assign done           = (rows > 0) && (next_row == rows);
    assign value_errors   = value_errs;
    assign latency_errors = latency_errs;
    assign count_errors   = count_errs;

    initial begin
        int          fd;
        int          rc;
        string       tag;
        string       rest;
        logic [15:0] w;
        logic [47:0] ebits;
        fd = $fopen(VEC_FILE, "r");
        if (fd == 0) begin
            $display("checker cannot open %s", VEC_FILE);   // done never rises, tb times out
        end else begin
            while ($fscanf(fd, "%s", tag) == 1) begin
                if (tag.getc(0) == "#") begin
                    rc = $fgets(rest, fd);            // skip comment line
                end else begin
                    for (int n = 0; n < 13; n++) begin
                        rc = $fscanf(fd, "%h", w);    // request words, not needed here
                    end
                    ebits = '0;
                    for (int n = 0; n < 3; n++) begin
                        rc = $fscanf(fd, "%h", w);
                        ebits = {ebits[31:0], w};     // x lands in the top word
                    end
                    names.push_back(tag);
                    expect_q.push_back(xform_pkg::vec3_t'(ebits));
                end
            end
            $fclose(fd);
            rows = expect_q.size();
        end
    end

    // one result, in order, exactly XFORM_LAT after its accept
    task automatic check_output();
        int lat;
        if (stamps.size() == 0 || next_row >= rows) begin
            $display("out_valid at cycle %0d with no request in flight", cycle);
            count_errs++;
            return;
        end
        lat = cycle - stamps.pop_front();
        if (lat != `XFORM_LAT) begin
            $display("%s came out after %0d cycles instead of %0d", names[next_row], lat,
                     `XFORM_LAT);
            latency_errs++;
        end
        if (out !== expect_q[next_row]) begin
            $display("FAILED %s expected %h actual %h", names[next_row], expect_q[next_row], out);
            value_errs++;
        end
        next_row++;
    endtask

    always @(posedge clk) begin
        if (rst) begin
            if (out_valid === 1'b1) begin
                $display("out_valid high during reset at cycle %0d", cycle);
                count_errs++;
            end
        end else begin
            if (in_valid) begin
                stamps.push_back(cycle);              // accepted on this edge
            end
            if (out_valid) begin
                check_output();
            end
        end
        cycle++;
    end

endmodule

`default_nettype wire

//--- verif/xform_tb.sv
`default_nettype none
`timescale 1ns/100ps

module xform_tb;

    localparam int DRAIN_LIMIT = 200;                 // cycles allowed after the last request

    logic                  clk;
    logic                  rst;
    logic                  in_valid;
    xform_pkg::xform_req_t req;
    logic                  out_valid;
    xform_pkg::vec3_t      out;
    logic                  done;
    int                    value_errors;
    int                    latency_errors;
    int                    count_errors;
    string                 names [$];                 // tag per row
    xform_pkg::xform_req_t reqs [$];
    int                    seed = 62;                 // idle gap generator

    xform_top dut (.*);

    xform_checker u_check (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;                       // 20 ns period
    end

    // request words of every row in file order
    task automatic load_requests(output logic ok);
        int                 fd;
        int                 rc;
        string              tag;
        string              rest;
        logic [15:0]        w;
        logic [13*16-1:0]   bits;
        ok = 1'b0;
        fd = $fopen("verif/xform_vectors.txt", "r");
        if (fd == 0) begin
            return;
        end
        while ($fscanf(fd, "%s", tag) == 1) begin
            if (tag.getc(0) == "#") begin
                rc = $fgets(rest, fd);
            end else begin
                bits = '0;
                for (int n = 0; n < 16; n++) begin
                    rc = $fscanf(fd, "%h", w);
                    if (n < 13) begin
                        bits = {bits[12*16-1:0], w};  // point.x ends up msb
                    end
                end
                names.push_back(tag);
                reqs.push_back(xform_pkg::xform_req_t'(bits));
            end
        end
        $fclose(fd);
        ok = 1'b1;
    endtask

    initial begin
        int   gap;
        int   waited;
        logic load_ok;
        logic timed_out;
        rst       = 1'b1;
        in_valid  = 1'b1;                             // strobe held through reset, dut ignores it
        req       = '0;
        waited    = 0;
        timed_out = 1'b0;
        load_requests(load_ok);
        if (!load_ok) begin
            $display("cannot open verif/xform_vectors.txt");
        end
        repeat (10) @(posedge clk);
        rst      <= 1'b0;
        in_valid <= 1'b0;
        for (int n = 0; n < reqs.size(); n++) begin
            gap = (names[n].substr(0, 2) == "b2b") ? 0 : $unsigned($random(seed)) % 4;
            repeat (gap) begin
                @(posedge clk);
                in_valid <= 1'b0;                     // idle cycle
            end
            @(posedge clk);
            in_valid <= 1'b1;
            req      <= reqs[n];
        end
        @(posedge clk);
        in_valid <= 1'b0;
        while (!done && waited < DRAIN_LIMIT) begin
            @(negedge clk);                           // checker state settled here
            waited++;
        end
        if (!done) begin
            timed_out = 1'b1;
            $display("timeout, outputs still missing after %0d cycles", DRAIN_LIMIT);
        end
        repeat (10) @(negedge clk);                   // room for a stray out_valid
        $display("value errors %0d, latency errors %0d, count errors %0d",
                 value_errors, latency_errors, count_errors);
        if (load_ok && !timed_out && value_errors == 0 && latency_errors == 0
            && count_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verif/xform_vectors.txt
# tag  point(x y z)  scale(x y z)  rot(r i j k)  trans(x y z)  expected(x y z)
# all words hex q3.12, rows tagged b2b_ go out back to back
ident_a     1234 abcd 0f0f 1000 1000 1000 1000 0000 0000 0000 0000 0000 0000 1234 abcd 0f0f
ident_b     7fff 8000 0001 1000 1000 1000 1000 0000 0000 0000 0000 0000 0000 7fff 8000 0001
scale_mix   1800 0800 f000 2000 1800 0c00 1000 0000 0000 0000 0100 ff00 0000 3100 0b00 f400
scale_floor 0001 ffff 0003 0800 0800 0800 1000 0000 0000 0000 0000 0000 0000 0000 ffff 0001
sat_mul     4000 4000 7000 4000 c000 1000 1000 0000 0000 0000 0000 0000 2000 7fff 8000 7fff
sat_add     9000 2000 0000 1000 1000 1000 1000 0000 0000 0000 e000 7000 0001 8000 7fff 0001
rot_x180    1000 2000 0800 1000 1000 1000 0000 1000 0000 0000 0000 0000 0000 1000 e000 f800
rot_y180    1000 2000 0800 1000 1000 1000 0000 0000 1000 0000 0000 0000 0000 f000 2000 f800
rot_z180    1000 2000 0800 1000 1000 1000 0000 0000 0000 1000 0000 0000 0000 f000 e000 0800
rot_x90     0000 1000 0000 1000 1000 1000 0b50 0b50 0000 0000 0000 0000 0000 0000 ffff 0fff
rot_y90     0000 0000 1000 1000 1000 1000 0b50 0000 0b50 0000 0000 0000 0000 0fff 0000 ffff
rot_z90     1000 0000 0000 1000 1000 1000 0b50 0000 0000 0b50 0000 0000 0000 ffff 0fff 0000
rot_z90_t   1000 0000 0000 1000 1000 1000 0b50 0000 0000 0b50 0001 0001 0001 0000 1000 0001
rot_diag    1000 0000 0000 1000 1000 1000 0800 0800 0800 0800 0000 0000 0000 0000 1000 0000
b2b_ident   0100 0200 0300 1000 1000 1000 1000 0000 0000 0000 0000 0000 0000 0100 0200 0300
b2b_x180    1000 2000 0800 1000 1000 1000 0000 1000 0000 0000 0000 0000 0000 1000 e000 f800
b2b_mix     1800 0800 f000 2000 1800 0c00 1000 0000 0000 0000 0100 ff00 0000 3100 0b00 f400
b2b_diag    1000 0000 0000 1000 1000 1000 0800 0800 0800 0800 0000 0000 0000 0000 1000 0000
b2b_sat     4000 4000 7000 4000 c000 1000 1000 0000 0000 0000 0000 0000 2000 7fff 8000 7fff
tail_y90    0000 0000 1000 1000 1000 1000 0b50 0000 0b50 0000 0000 0000 0000 0fff 0000 ffff

//--- tb.f
+incdir+common
common/xform_pkg.sv
rtl/pipe_delay.sv
rtl/vec_scale.sv
rotate/quat_mult.sv
rotate/vec_rotate.sv
rtl/vec_translate.sv
rtl/xform_top.sv
verif/xform_checker.sv
verif/xform_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f tb.f --top-module xform_tb -o xform_sim
./obj_dir/xform_sim | tee sim.log
if grep -q "Verification passed" sim.log; then
    echo "PASS"
else
    echo "FAIL"
    exit 1
fi
